// File: tb.f
gpio_pkg.sv
gpio_regs.sv
gpio_pin.sv
gpio_irq.sv
gpio_top.sv
tb_gpio_checker.sv
tb_gpio.sv

// File: Bender.yml
package:
  name: gpio

# Compile order matches tb.f
sources:
  - gpio_pkg.sv
  - gpio_regs.sv
  - gpio_pin.sv
  - gpio_irq.sv
  - gpio_top.sv
  - target: simulation
    files:
      - tb_gpio_checker.sv
      - tb_gpio.sv

// File: tb_gpio.sv
// Pads read external levels where output enable is low; each access is followed by idle cycles
`timescale 1ns/1ps

module tb_gpio import gpio_pkg::*; ();

  localparam logic [31:0] SEED = 32'h369bd71c;

  // Test lengths in iterations
  localparam int N_WR   = 40;
  localparam int N_IN   = 24;
  localparam int N_EDGE = 32;
  localparam int N_IRQ  = 24;

  // Bus accesses and pad changes per test
  localparam int OPS_T1 = 8;
  localparam int OPS_T2 = 2 * N_WR;
  localparam int OPS_T3 = 4 * N_IN;
  localparam int OPS_T4 = 2 + 4 * N_EDGE;
  localparam int OPS_T5 = 5 * N_IRQ + 2;
  localparam int TOTAL_OPS = OPS_T1 + OPS_T2 + OPS_T3 + OPS_T4 + OPS_T5;
  localparam int TIMEOUT_CYC = TOTAL_OPS * 8 + 100;

  logic              clk;
  logic              rst_n;
  logic              bus_sel;
  logic              bus_we;
  logic              bus_re;
  logic [BUS_AW-1:0] bus_addr;
  logic [BUS_DW-1:0] bus_wdata;
  logic [BUS_DW-1:0] bus_rdata;
  logic              bus_rvalid;
  logic [GPIO_W-1:0] ext_lvl;
  logic [GPIO_W-1:0] pad_in;
  logic [GPIO_W-1:0] pad_out;
  logic [GPIO_W-1:0] pad_oe;
  logic              irq;
  int                checks;
  int                errors;
  int                cycles = 0;

  // Bidirectional pin: driven value wins where the output is enabled
  assign pad_in = (pad_oe & pad_out) | (~pad_oe & ext_lvl);

  gpio_top dut0 (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_bus_sel    (bus_sel),
    .i_bus_we     (bus_we),
    .i_bus_re     (bus_re),
    .i_bus_addr   (bus_addr),
    .i_bus_wdata  (bus_wdata),
    .o_bus_rdata  (bus_rdata),
    .o_bus_rvalid (bus_rvalid),
    .i_pad_in     (pad_in),
    .o_pad_out    (pad_out),
    .o_pad_oe     (pad_oe),
    .o_irq        (irq)
  );

  tb_gpio_checker chk0 (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_bus_sel    (bus_sel),
    .i_bus_we     (bus_we),
    .i_bus_re     (bus_re),
    .i_bus_addr   (bus_addr),
    .i_bus_wdata  (bus_wdata),
    .i_bus_rdata  (bus_rdata),
    .i_bus_rvalid (bus_rvalid),
    .i_ext        (ext_lvl),
    .i_pad_out    (pad_out),
    .i_pad_oe     (pad_oe),
    .i_irq        (irq),
    .o_checks     (checks),
    .o_errors     (errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic write_reg(input logic [BUS_AW-1:0] a, input logic [BUS_DW-1:0] d);
    @(posedge clk);
    #2;
    bus_sel   = 1'b1;
    bus_we    = 1'b1;
    bus_addr  = a;
    bus_wdata = d;
    @(posedge clk);
    #2;
    bus_sel = 1'b0;
    bus_we  = 1'b0;
    idle_cycles(3);
  endtask

  task automatic read_reg(input logic [BUS_AW-1:0] a);
    @(posedge clk);
    #2;
    bus_sel  = 1'b1;
    bus_re   = 1'b1;
    bus_addr = a;
    @(posedge clk);
    #2;
    bus_sel = 1'b0;
    bus_re  = 1'b0;
    // Data itself is judged by the checker
    while (!bus_rvalid) begin
      @(posedge clk);
      #2;
    end
    idle_cycles(3);
  endtask

  // New external level, then let it pass the synchroniser
  task automatic set_ext_level(input logic [GPIO_W-1:0] v);
    @(posedge clk);
    #2;
    ext_lvl = v;
    idle_cycles(4);
  endtask

  function automatic logic [GPIO_W-1:0] rand_pins();
    logic [31:0] r;
    r = $urandom;
    return r[GPIO_W-1:0];
  endfunction

  // Writable registers plus the two unmapped addresses
  function automatic logic [BUS_AW-1:0] pick_cfg_addr();
    int unsigned r;
    r = $urandom % 6;
    case (r)
      0:       return REG_OUT;
      1:       return REG_DIR;
      2:       return REG_MODE;
      3:       return REG_MASK;
      4:       return 3'd6;
      default: return 3'd7;
    endcase
  endfunction

  task automatic print_test_result(input int n, input string name, input int base);
    $display("test %0d %s finished with %0d errors", n, name, errors - base);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYC) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin : main
    int                base;
    logic [BUS_AW-1:0] a;
    logic [BUS_DW-1:0] d;
    bus_sel   = 1'b0;
    bus_we    = 1'b0;
    bus_re    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    ext_lvl   = '0;
    rst_n     = 1'b0;
    void'($urandom(SEED));
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    idle_cycles(4);

    base = errors;
    for (int i = 0; i < 8; i++) begin
      read_reg(i[BUS_AW-1:0]);
    end
    print_test_result(1, "reset values", base);

    base = errors;
    for (int i = 0; i < N_WR; i++) begin
      a = pick_cfg_addr();
      d = $urandom;
      write_reg(a, d);
      read_reg(a);
    end
    print_test_result(2, "register write and read back", base);

    base = errors;
    for (int i = 0; i < N_IN; i++) begin
      write_reg(REG_DIR, {20'd0, rand_pins()});
      write_reg(REG_OUT, {20'd0, rand_pins()});
      set_ext_level(rand_pins());
      read_reg(REG_IN);
    end
    print_test_result(3, "input sampling", base);

    base = errors;
    write_reg(REG_DIR, '0);
    write_reg(REG_PEND, '1);
    for (int i = 0; i < N_EDGE; i++) begin
      write_reg(REG_MODE, $urandom);
      set_ext_level(ext_lvl ^ rand_pins());
      read_reg(REG_PEND);
      write_reg(REG_PEND, '1);
    end
    print_test_result(4, "edge detection", base);

    base = errors;
    for (int i = 0; i < N_IRQ; i++) begin
      write_reg(REG_MASK, {20'd0, rand_pins()});
      set_ext_level(ext_lvl ^ rand_pins());
      read_reg(REG_PEND);
      write_reg(REG_PEND, {20'd0, rand_pins()});
      read_reg(REG_PEND);
    end
    // Nothing left pending, so the line must drop
    write_reg(REG_PEND, '1);
    read_reg(REG_PEND);
    print_test_result(5, "interrupt mask and clear", base);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: tb_gpio_checker.sv
// Samples on the falling clock; pads and irq are compared only after four quiet cycles
`timescale 1ns/1ps

module tb_gpio_checker import gpio_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_bus_sel,
  input  logic              i_bus_we,
  input  logic              i_bus_re,
  input  logic [BUS_AW-1:0] i_bus_addr,
  input  logic [BUS_DW-1:0] i_bus_wdata,
  input  logic [BUS_DW-1:0] i_bus_rdata,
  input  logic              i_bus_rvalid,
  input  logic [GPIO_W-1:0] i_ext,
  input  logic [GPIO_W-1:0] i_pad_out,
  input  logic [GPIO_W-1:0] i_pad_oe,
  input  logic              i_irq,
  output int                o_checks,
  output int                o_errors
);

  // Quiet cycles before pads and irq are expected to match the model
  localparam int SETTLE = 4;

  logic [GPIO_W-1:0] out_m;
  logic [GPIO_W-1:0] dir_m;
  logic [MODE_W-1:0] mode_m;
  logic [GPIO_W-1:0] mask_m;
  logic [GPIO_W-1:0] pend_m;
  logic [GPIO_W-1:0] pad_prev;
  logic [BUS_DW-1:0] rd_exp;
  logic [BUS_AW-1:0] rd_addr;
  logic              rd_wait = 1'b0;
  int                quiet = 0;
  int                chk_cnt = 0;
  int                err_cnt = 0;

  assign o_checks = chk_cnt;
  assign o_errors = err_cnt;

  task automatic compare_val(input string name, input logic [BUS_DW-1:0] exp_v,
                             input logic [BUS_DW-1:0] got_v);
    chk_cnt++;
    if (got_v !== exp_v) begin
      err_cnt++;
      $display("error at time %0t: %s expected %h, got %h", $time, name, exp_v, got_v);
    end
  endtask

  task automatic report_fault(input string what);
    err_cnt++;
    $display("failure at time %0t: %s", $time, what);
  endtask

  // Level seen on each pin
  function automatic logic [GPIO_W-1:0] model_pad();
    return (dir_m & out_m) | (~dir_m & i_ext);
  endfunction

  function automatic logic edge_hit(input edge_mode_e m, input logic was, input logic now);
    case (m)
      EDGE_RISE: return !was && now;
      EDGE_FALL: return was && !now;
      EDGE_BOTH: return was != now;
      default:   return 1'b0;
    endcase
  endfunction

  function automatic logic [BUS_DW-1:0] read_value(input logic [BUS_AW-1:0] a);
    logic [BUS_DW-1:0] v;
    v = '0;
    case (a)
      REG_OUT:  v[GPIO_W-1:0] = out_m;
      REG_DIR:  v[GPIO_W-1:0] = dir_m;
      REG_IN:   v[GPIO_W-1:0] = model_pad();
      REG_MODE: v[MODE_W-1:0] = mode_m;
      REG_MASK: v[GPIO_W-1:0] = mask_m;
      REG_PEND: v[GPIO_W-1:0] = pend_m;
      default:  v = '0;
    endcase
    return v;
  endfunction

  always @(negedge i_clk) begin : watch
    logic [GPIO_W-1:0] pad_now;
    if (!i_rst_n) begin
      out_m    = '0;
      dir_m    = '0;
      mode_m   = '0;
      mask_m   = '0;
      pend_m   = '0;
      pad_prev = '0;
      rd_wait  = 1'b0;
      quiet    = 0;
    end else begin
      // Response to the read seen one cycle ago
      if (rd_wait) begin
        if (!i_bus_rvalid) begin
          report_fault($sformatf("no read response for address %0d", rd_addr));
        end else begin
          compare_val($sformatf("o_bus_rdata (addr %0d)", rd_addr), rd_exp, i_bus_rdata);
        end
        rd_wait = 1'b0;
      end else if (i_bus_rvalid) begin
        report_fault("read response without a read strobe");
      end

      if (quiet >= SETTLE) begin
        compare_val("o_pad_out", out_m, i_pad_out);
        compare_val("o_pad_oe", dir_m, i_pad_oe);
        compare_val("o_irq", |(pend_m & mask_m), i_irq);
      end

      if (i_bus_sel && i_bus_re) begin
        rd_addr = i_bus_addr;
        rd_exp  = read_value(i_bus_addr);
        rd_wait = 1'b1;
      end
      if (i_bus_sel && i_bus_we) begin
        case (i_bus_addr)
          REG_OUT:  out_m  = i_bus_wdata[GPIO_W-1:0];
          REG_DIR:  dir_m  = i_bus_wdata[GPIO_W-1:0];
          REG_MODE: mode_m = i_bus_wdata[MODE_W-1:0];
          REG_MASK: mask_m = i_bus_wdata[GPIO_W-1:0];
          REG_PEND: pend_m = pend_m & ~i_bus_wdata[GPIO_W-1:0];
          default: ;
        endcase
        quiet = 0;
      end

      // Edge rule applied to the modelled pad levels
      pad_now = model_pad();
      for (int i = 0; i < GPIO_W; i++) begin
        if (edge_hit(edge_mode_e'(mode_m[2*i +: 2]), pad_prev[i], pad_now[i])) begin
          pend_m[i] = 1'b1;
        end
      end
      if (pad_now != pad_prev) begin
        quiet = 0;
      end
      pad_prev = pad_now;
      if (quiet < SETTLE) begin
        quiet++;
      end
    end
  end

endmodule

// File: gpio_top.sv
// Pads come split as in/out/oe; the tristate buffer belongs to the chip level
`timescale 1ns/1ps

module gpio_top import gpio_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_bus_sel,
  input  logic              i_bus_we,
  input  logic              i_bus_re,
  input  logic [BUS_AW-1:0] i_bus_addr,
  input  logic [BUS_DW-1:0] i_bus_wdata,
  output logic [BUS_DW-1:0] o_bus_rdata,
  output logic              o_bus_rvalid,
  input  logic [GPIO_W-1:0] i_pad_in,
  output logic [GPIO_W-1:0] o_pad_out,
  output logic [GPIO_W-1:0] o_pad_oe,
  output logic              o_irq
);

  pin_cfg_t  [GPIO_W-1:0] w_pin_cfg;
  pin_stat_t [GPIO_W-1:0] w_pin_stat;
  logic      [GPIO_W-1:0] w_in_sync;
  logic      [GPIO_W-1:0] w_edge_evt;
  logic      [GPIO_W-1:0] w_irq_mask;
  logic      [GPIO_W-1:0] w_pend_clr;
  logic      [GPIO_W-1:0] w_pend;

  gpio_regs regs0 (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_bus_sel    (i_bus_sel),
    .i_bus_we     (i_bus_we),
    .i_bus_re     (i_bus_re),
    .i_bus_addr   (i_bus_addr),
    .i_bus_wdata  (i_bus_wdata),
    .o_bus_rdata  (o_bus_rdata),
    .o_bus_rvalid (o_bus_rvalid),
    .i_in_sync    (w_in_sync),
    .i_pend       (w_pend),
    .o_pin_cfg    (w_pin_cfg),
    .o_irq_mask   (w_irq_mask),
    .o_pend_clr   (w_pend_clr)
  );

  // One cell per pad
  for (genvar i = 0; i < GPIO_W; i++) begin : pinx
    gpio_pin pin0 (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_pad     (i_pad_in[i]),
      .i_cfg     (w_pin_cfg[i]),
      .o_stat    (w_pin_stat[i]),
      .o_pad_out (o_pad_out[i]),
      .o_pad_oe  (o_pad_oe[i])
    );
    assign w_in_sync[i]  = w_pin_stat[i].in_sync;
    assign w_edge_evt[i] = w_pin_stat[i].edge_evt;
  end

  gpio_irq irq0 (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_evt   (w_edge_evt),
    .i_mask  (w_irq_mask),
    .i_clr   (w_pend_clr),
    .o_pend  (w_pend),
    .o_irq   (o_irq)
  );

endmodule

// File: gpio_irq.sv
// Pending bits are sticky until written one; a new event in the clear cycle keeps the bit set
`timescale 1ns/1ps

module gpio_irq import gpio_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic [GPIO_W-1:0] i_evt,
  input  logic [GPIO_W-1:0] i_mask,
  input  logic [GPIO_W-1:0] i_clr,
  output logic [GPIO_W-1:0] o_pend,
  output logic              o_irq
);

  logic [GPIO_W-1:0] pend_q;
  logic [GPIO_W-1:0] pend_d;

  // Set wins over clear
  assign pend_d = i_evt | (pend_q & ~i_clr);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_d;
    end
  end

  assign o_pend = pend_q;

  // Single interrupt line, no flop in the path
  assign o_irq = |(pend_q & i_mask);

  // A pending bit only rises on an event seen the cycle before
  a_pend_needs_evt: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    ((o_pend & ~$past(o_pend)) & ~$past(i_evt)) == '0
  ) else $error("pending bit set without an edge event");

endmodule

// File: gpio_pin.sv
// Pad input is asynchronous; two flops resync it, so edges show up two clocks late
`timescale 1ns/1ps

module gpio_pin import gpio_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_pad,
  input  pin_cfg_t  i_cfg,
  output pin_stat_t o_stat,
  output logic      o_pad_out,
  output logic      o_pad_oe
);

  logic meta_q;
  logic sync_q;
  logic hist_q;
  logic rise;
  logic fall;
  logic evt;

  // Synchroniser plus one history stage
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      meta_q <= 1'b0;
      sync_q <= 1'b0;
      hist_q <= 1'b0;
    end else begin
      meta_q <= i_pad;
      sync_q <= meta_q;
      hist_q <= sync_q;
    end
  end

  assign rise = sync_q & ~hist_q;
  assign fall = ~sync_q & hist_q;

  // Edge filter by mode
  always_comb begin
    case (i_cfg.mode)
      EDGE_RISE: evt = rise;
      EDGE_FALL: evt = fall;
      EDGE_BOTH: evt = rise | fall;
      default:   evt = 1'b0;
    endcase
  end

  assign o_stat.in_sync  = sync_q;
  assign o_stat.edge_evt = evt;

  // Output side is straight from the config registers
  assign o_pad_out = i_cfg.out_val;
  assign o_pad_oe  = i_cfg.out_en;

endmodule

// File: gpio_regs.sv
// Strobe bus without handshake; one read or write per cycle, read data one clock later
`timescale 1ns/1ps

module gpio_regs import gpio_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_bus_sel,
  input  logic                    i_bus_we,
  input  logic                    i_bus_re,
  input  logic [BUS_AW-1:0]       i_bus_addr,
  input  logic [BUS_DW-1:0]       i_bus_wdata,
  output logic [BUS_DW-1:0]       o_bus_rdata,
  output logic                    o_bus_rvalid,
  input  logic [GPIO_W-1:0]       i_in_sync,
  input  logic [GPIO_W-1:0]       i_pend,
  output pin_cfg_t [GPIO_W-1:0]   o_pin_cfg,
  output logic [GPIO_W-1:0]       o_irq_mask,
  output logic [GPIO_W-1:0]       o_pend_clr
);

  reg_addr_e          addr;
  logic               wr_en;
  logic               rd_en;
  logic [GPIO_W-1:0]  out_q;
  logic [GPIO_W-1:0]  dir_q;
  logic [MODE_W-1:0]  mode_q;
  logic [GPIO_W-1:0]  mask_q;
  logic [BUS_DW-1:0]  rd_mux;

  assign addr  = reg_addr_e'(i_bus_addr);
  assign wr_en = i_bus_sel & i_bus_we;
  assign rd_en = i_bus_sel & i_bus_re;

  // Configuration registers
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      out_q  <= '0;
      dir_q  <= '0;
      mode_q <= '0;
      mask_q <= '0;
    end else if (wr_en) begin
      case (addr)
        REG_OUT:  out_q  <= i_bus_wdata[GPIO_W-1:0];
        REG_DIR:  dir_q  <= i_bus_wdata[GPIO_W-1:0];
        REG_MODE: mode_q <= i_bus_wdata[MODE_W-1:0];
        REG_MASK: mask_q <= i_bus_wdata[GPIO_W-1:0];
        default: ;
      endcase
    end
  end

  // Pending bits are cleared by writing ones
  assign o_pend_clr = (wr_en && addr == REG_PEND) ? i_bus_wdata[GPIO_W-1:0] : '0;
  assign o_irq_mask = mask_q;

  // Per-pin view of the registers
  always_comb begin
    for (int i = 0; i < GPIO_W; i++) begin
      o_pin_cfg[i].out_val = out_q[i];
      o_pin_cfg[i].out_en  = dir_q[i];
      o_pin_cfg[i].mode    = edge_mode_e'(mode_q[2*i +: 2]);
    end
  end

  // Read mux, upper bits zero
  always_comb begin
    rd_mux = '0;
    case (addr)
      REG_OUT:  rd_mux[GPIO_W-1:0] = out_q;
      REG_DIR:  rd_mux[GPIO_W-1:0] = dir_q;
      REG_IN:   rd_mux[GPIO_W-1:0] = i_in_sync;
      REG_MODE: rd_mux[MODE_W-1:0] = mode_q;
      REG_MASK: rd_mux[GPIO_W-1:0] = mask_q;
      REG_PEND: rd_mux[GPIO_W-1:0] = i_pend;
      default:  rd_mux = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_bus_rvalid <= 1'b0;
      o_bus_rdata  <= '0;
    end else begin
      o_bus_rvalid <= rd_en;
      if (rd_en) begin
        o_bus_rdata <= rd_mux;
      end
    end
  end

  // Read response only follows a selected read
  a_rvalid_after_read: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_bus_rvalid |-> $past(i_bus_sel && i_bus_re)
  ) else $error("rvalid without a preceding read strobe");

  // Master never writes and reads in one access
  a_no_rw_collision: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_bus_sel |-> !(i_bus_we && i_bus_re)
  ) else $error("write and read strobes together");

endmodule

// File: gpio_pkg.sv
// Pin count and register map are fixed here; bus is 32-bit data with 3-bit word addresses
package gpio_pkg;

  // Number of pads handled by the block
  localparam int GPIO_W = 12;

  // Bus widths
  localparam int BUS_AW = 3;
  localparam int BUS_DW = 32;

  // Two mode bits per pin in REG_MODE
  localparam int MODE_W = 2 * GPIO_W;

  // Register map, word addressed
  typedef enum logic [BUS_AW-1:0] {
    REG_OUT  = 3'd0,
    REG_DIR  = 3'd1,
    REG_IN   = 3'd2,
    REG_MODE = 3'd3,
    REG_MASK = 3'd4,
    REG_PEND = 3'd5
  } reg_addr_e;

  // Edge selection for the interrupt source of a pin
  typedef enum logic [1:0] {
    EDGE_NONE = 2'd0,
    EDGE_RISE = 2'd1,
    EDGE_FALL = 2'd2,
    EDGE_BOTH = 2'd3
  } edge_mode_e;

  // Configuration of one pin cell
  typedef struct packed {
    logic       out_val;
    logic       out_en;
    edge_mode_e mode;
  } pin_cfg_t;

  // Status returned by one pin cell
  typedef struct packed {
    logic in_sync;
    // One-cycle pulse
    logic edge_evt;
  } pin_stat_t;

endpackage
